// ==== dv/icache_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_asserts (
  input wire logic                          clk_i,
  input wire logic                          rst_n_i,
  input wire logic                          if_ack_i,
  input wire logic                          imem_req_i,
  input wire logic                          imem_ack_i,
  input wire logic [icache_pkg::ADDR_W-1:0] imem_addr_i,
  input wire icache_pkg::icache_state_e     state_i
);

  int unsigned fail_count = 0;                // Failed assertions so far.

  // Fetch ack is a single-cycle pulse.
  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    if_ack_i |=> !if_ack_i)
    else begin
      fail_count++;
      $error("if_ack_o high for two cycles");
    end

  // Memory request stays up until its ack.
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    imem_req_i && !imem_ack_i |=> imem_req_i)
    else begin
      fail_count++;
      $error("imem_req_o dropped before imem_ack_i");
    end

  addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    imem_req_i && !imem_ack_i |=> $stable(imem_addr_i))
    else begin
      fail_count++;
      $error("imem_addr_o changed during an open request");
    end

  // Quiet outputs and idle FSM out of reset.
  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |=> !if_ack_i && !imem_req_i && (state_i == icache_pkg::ST_IDLE))
    else begin
      fail_count++;
      $error("outputs or state not cleared by reset");
    end

endmodule

bind icache_top icache_asserts u_asserts (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .if_ack_i    (if_ack_o),
  .imem_req_i  (imem_req_o),
  .imem_ack_i  (imem_ack_i),
  .imem_addr_i (imem_addr_o),
  .state_i     (u_controller.state_q)
);

`default_nettype wire

// ==== dv/tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  localparam int          LINE_WORDS = icache_pkg::DEF_LINE_WORDS;
  localparam int          TIMEOUT    = 200;      // Cycles allowed per wait.
  localparam int          HIT_CYCLES = 3;        // Falling edges from request drive to ack.
  localparam logic [31:0] DATA_MASK  = 32'hA5A5_0000;

  logic        clk;
  logic        rst_n;
  logic        imem_sel;
  logic        if_req;
  logic        if_req_kill;
  logic        icache_flush;
  logic [31:0] if_addr;
  logic        if_ack;
  logic [31:0] if_data;
  logic        imem_ack;
  logic [31:0] imem_data;
  logic        imem_req;
  logic [31:0] imem_addr;

  int unsigned check_errors;
  int unsigned timeout_errors;
  int unsigned assert_errors;
  logic [31:0] mem_addrs[$];                     // Memory request addresses of one fetch.

  icache_top i_dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .imem_sel_i     (imem_sel),
    .if_req_i       (if_req),
    .if_req_kill_i  (if_req_kill),
    .icache_flush_i (icache_flush),
    .if_addr_i      (if_addr),
    .if_ack_o       (if_ack),
    .if_data_o      (if_data),
    .imem_ack_i     (imem_ack),
    .imem_data_i    (imem_data),
    .imem_req_o     (imem_req),
    .imem_addr_o    (imem_addr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Memory contents: word address XOR a fixed mask.
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {2'b00, addr[31:2]} ^ DATA_MASK;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    check_errors++;
    $display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
  endtask

  task automatic report_failure(input string msg);
    check_errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    timeout_errors++;
    $display("ERROR t=%0t timed out waiting for %s", $time, what);
  endtask

  // One ack per request, 1 to 5 cycles after the request rises.
  initial begin : memory_model
    int unsigned lat;
    logic [31:0] addr;
    imem_ack  = 1'b0;
    imem_data = '0;
    forever begin
      @(negedge clk);
      if (rst_n && imem_req) begin
        addr = imem_addr;
        mem_addrs.push_back(addr);
        lat = $urandom_range(5, 1);
        repeat (lat) @(posedge clk);
        imem_ack  <= 1'b1;
        imem_data <= mem_word(addr);
        @(posedge clk);
        imem_ack  <= 1'b0;
      end
    end
  end

  task automatic drive_request(input logic [31:0] addr, input logic sel);
    @(posedge clk);
    if_req   <= 1'b1;
    if_addr  <= addr;
    imem_sel <= sel;
  endtask

  // Waits for the ack, checks its data and drops the request after it.
  task automatic await_ack(input logic [31:0] addr, output int cycles);
    bit got_ack;
    got_ack = 1'b0;
    cycles  = 0;
    while (!got_ack && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (if_ack) begin
        got_ack = 1'b1;
        assert (if_data == mem_word(addr))
          else report_mismatch("if_data_o", mem_word(addr), if_data);
      end
    end
    @(posedge clk);
    if_req <= 1'b0;
    if (!got_ack) begin
      report_timeout("if_ack_o");
    end
  endtask

  // A miss refills the whole line in order, a hit touches no memory.
  task automatic check_access(input logic [31:0] addr, input bit exp_miss, input int cycles);
    logic [31:0] base;
    base = addr & ~32'(LINE_WORDS * 4 - 1);
    if (exp_miss) begin
      assert (mem_addrs.size() == LINE_WORDS)
        else report_mismatch("imem_req_o count", LINE_WORDS, mem_addrs.size());
      foreach (mem_addrs[i]) begin
        assert (mem_addrs[i] == base + 32'(i * 4))
          else report_mismatch("imem_addr_o", base + 32'(i * 4), mem_addrs[i]);
      end
    end else begin
      assert (mem_addrs.size() == 0)
        else report_mismatch("imem_req_o count", 0, mem_addrs.size());
      assert (cycles == HIT_CYCLES)
        else report_mismatch("if_ack_o latency", HIT_CYCLES, cycles);
    end
  endtask

  task automatic fetch(input logic [31:0] addr, input bit exp_miss);
    int cycles;
    mem_addrs.delete();
    drive_request(addr, 1'b1);
    await_ack(addr, cycles);
    check_access(addr, exp_miss, cycles);
  endtask

  task automatic wait_mem_idle();
    int cycles;
    cycles = 0;
    while ((imem_req || imem_ack) && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (imem_req || imem_ack) begin
      report_timeout("memory idle");
    end
  endtask

  // Kills a fetch once its refill is under way.
  task automatic fetch_killed(input logic [31:0] addr);
    int cycles;
    mem_addrs.delete();
    drive_request(addr, 1'b1);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!imem_req && cycles < TIMEOUT);
    if (!imem_req) begin
      report_timeout("refill start");
    end
    @(posedge clk);
    if_req      <= 1'b0;
    if_req_kill <= 1'b1;
    @(posedge clk);
    if_req_kill <= 1'b0;
    repeat (30) begin
      @(negedge clk);
      assert (!if_ack) else report_failure("if_ack_o given for a killed fetch");
    end
    wait_mem_idle();
  endtask

  task automatic flush_pulse();
    @(posedge clk);
    icache_flush <= 1'b1;
    @(posedge clk);
    icache_flush <= 1'b0;
  endtask

  initial begin : main_seq
    int          cycles;
    logic [31:0] addr;
    void'($urandom(32'h5fbe861c));
    rst_n          = 1'b0;
    imem_sel       = 1'b1;
    if_req         = 1'b0;
    if_req_kill    = 1'b0;
    icache_flush   = 1'b0;
    if_addr        = '0;
    check_errors   = 0;
    timeout_errors = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    fetch(32'h0000_0100, 1'b1);                  // Cold miss.
    for (int w = 0; w < LINE_WORDS; w++) begin
      fetch(32'h0000_0100 + 32'(w * 4), 1'b0);
    end
    addr = 32'h0000_0100 + 32'(4 * $urandom_range(LINE_WORDS - 1, 0));
    fetch(addr, 1'b0);

    fetch_killed(32'h0000_0200);
    fetch(32'h0000_0208, 1'b1);                  // Killed line was never validated.
    fetch(32'h0000_0200, 1'b0);

    fetch(32'h0000_0300, 1'b1);
    fetch(32'h0000_0304, 1'b0);
    flush_pulse();
    fetch(32'h0000_030C, 1'b1);

    // Held request with the cache deselected.
    mem_addrs.delete();
    drive_request(32'h0000_0400, 1'b0);
    repeat (20) begin
      @(negedge clk);
      assert (!if_ack && !imem_req) else report_failure("fetch served while imem_sel_i low");
    end
    @(posedge clk);
    imem_sel <= 1'b1;
    await_ack(32'h0000_0400, cycles);
    check_access(32'h0000_0400, 1'b1, cycles);

    // Same set, different tags.
    fetch(32'h0000_2040, 1'b1);
    fetch(32'h0000_3040, 1'b1);
    fetch(32'h0000_2048, 1'b1);
    fetch(32'h0000_304C, 1'b1);
    wait_mem_idle();

    assert_errors = i_dut.u_asserts.fail_count;
    $display("Errors: checks=%0d timeouts=%0d assertions=%0d",
             check_errors, timeout_errors, assert_errors);
    if (check_errors + timeout_errors + assert_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the icache testbench with Verilator, pass only if the log says so.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_icache -f src.f \
  && ./obj_dir/Vtb_icache +verilator+error+limit+100 > sim.log 2>&1 \
  || echo "Build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "^ALL CHECKS PASSED$" sim.log && exit 0 || exit 1

// ==== src.f ====
verilog/icache_pkg.sv
verilog/icache_word_counter.sv
verilog/icache_controller.sv
verilog/icache_datapath.sv
verilog/icache_top.sv
dv/icache_asserts.sv
dv/tb_icache.sv

// ==== verilog/icache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_controller (
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,

  // Fetch side.
  input  wire logic            if_req_i,
  input  wire logic            if_req_kill_i,
  input  wire logic            icache_flush_i,
  input  wire logic            imem_sel_i,
  output logic                 if_ack_o,

  // Memory side.
  input  wire logic            imem_ack_i,
  output logic                 imem_req_o,

  // Datapath and counter.
  input  wire logic            cache_hit_i,
  input  wire logic            cnt_last_i,
  input  wire logic            cnt_word_last_i,
  output logic                 cache_rw_o,
  output logic                 line_fill_o,
  output logic                 flush_clr_o,
  output icache_pkg::cnt_op_e  cnt_op_o
);

  icache_pkg::icache_state_e state_q;
  icache_pkg::icache_state_e state_d;

  logic lookup_q;                       // Hit compare in flight, result arrives next cycle.
  logic lookup_d;
  logic ack_d;
  logic req_d;
  logic flush_pend_q;                   // Flush seen while busy, served back in idle.
  logic flush_pend_d;
  logic flush_req;

  assign flush_req = icache_flush_i | flush_pend_q;

  always_comb begin
    state_d      = state_q;
    lookup_d     = 1'b0;
    ack_d        = 1'b0;
    req_d        = imem_req_o;
    flush_pend_d = flush_pend_q | icache_flush_i;
    cnt_op_o     = icache_pkg::CNT_HOLD;
    cache_rw_o   = 1'b0;
    line_fill_o  = 1'b0;
    flush_clr_o  = 1'b0;

    unique case (state_q)
      icache_pkg::ST_IDLE: begin
        flush_pend_d = 1'b0;
        if (flush_req) begin
          state_d  = icache_pkg::ST_FLUSH;    // Any lookup in flight is dropped and redone.
          cnt_op_o = icache_pkg::CNT_CLEAR;
        end else if (lookup_q) begin
          if (if_req_kill_i || !imem_sel_i) begin
            ack_d = 1'b0;                     // Request withdrawn, nothing to answer.
          end else if (cache_hit_i) begin
            ack_d = 1'b1;
          end else begin
            state_d  = icache_pkg::ST_REFILL;
            req_d    = 1'b1;                  // First word goes out with the counter at zero.
            cnt_op_o = icache_pkg::CNT_CLEAR;
          end
        end else begin
          // The ack cycle still sees the old request, so it must not start a lookup.
          lookup_d = if_req_i & imem_sel_i & ~if_req_kill_i & ~if_ack_o;
        end
      end

      icache_pkg::ST_REFILL: begin
        if (imem_ack_i) begin
          cache_rw_o = 1'b1;                  // Store the returned word.
          req_d      = 1'b0;                  // Request drops for one cycle after each ack.
          cnt_op_o   = icache_pkg::CNT_INC;
        end
        if (if_req_kill_i) begin
          if (imem_req_o && !imem_ack_i) begin
            state_d = icache_pkg::ST_DRAIN;   // Transaction still open.
          end else begin
            state_d = icache_pkg::ST_IDLE;
            req_d   = 1'b0;
          end
        end else if (imem_ack_i) begin
          if (cnt_word_last_i) begin
            line_fill_o = 1'b1;               // Tag and valid with the last word.
            state_d     = icache_pkg::ST_IDLE;
          end
        end else if (!imem_req_o) begin
          req_d = 1'b1;                       // Next word, counter already stepped.
        end
      end

      icache_pkg::ST_DRAIN: begin
        if (imem_ack_i) begin
          req_d   = 1'b0;
          state_d = icache_pkg::ST_IDLE;
        end
      end

      icache_pkg::ST_FLUSH: begin
        flush_clr_o = 1'b1;                   // Clear the set under the counter.
        cnt_op_o    = icache_pkg::CNT_INC;
        if (cnt_last_i) begin
          state_d = icache_pkg::ST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= icache_pkg::ST_IDLE;
      lookup_q     <= 1'b0;
      if_ack_o     <= 1'b0;
      imem_req_o   <= 1'b0;
      flush_pend_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      lookup_q     <= lookup_d;
      if_ack_o     <= ack_d;
      imem_req_o   <= req_d;
      flush_pend_q <= flush_pend_d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/icache_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_datapath #(
  parameter int NUM_SETS   = 16,
  parameter int LINE_WORDS = 4
) (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_n_i,

  // Controller.
  input  wire logic                                  cache_rw_i,
  input  wire logic                                  line_fill_i,
  input  wire logic                                  flush_clr_i,
  output logic                                       cache_hit_o,

  // Counter.
  input  wire logic [$clog2((NUM_SETS > LINE_WORDS) ?
                            NUM_SETS : LINE_WORDS)-1:0] count_i,

  // Fetch side.
  input  wire logic [icache_pkg::ADDR_W-1:0]         if_addr_i,
  output logic      [icache_pkg::DATA_W-1:0]         if_data_o,

  // Memory side.
  input  wire logic [icache_pkg::DATA_W-1:0]         imem_data_i,
  output logic      [icache_pkg::ADDR_W-1:0]         imem_addr_o
);

  localparam int WORD_W = $clog2(LINE_WORDS);
  localparam int IDX_W  = $clog2(NUM_SETS);
  localparam int TAG_W  = icache_pkg::ADDR_W - IDX_W - WORD_W - 2;

  // Address split: tag, set index, word in line, byte in word.
  logic [TAG_W-1:0]  addr_tag;
  logic [IDX_W-1:0]  addr_idx;
  logic [WORD_W-1:0] addr_word;

  assign addr_tag  = if_addr_i[icache_pkg::ADDR_W-1 -: TAG_W];
  assign addr_idx  = if_addr_i[2+WORD_W +: IDX_W];
  assign addr_word = if_addr_i[2 +: WORD_W];

  logic [icache_pkg::DATA_W-1:0] data_mem [NUM_SETS*LINE_WORDS];
  logic [TAG_W-1:0]              tag_mem  [NUM_SETS];
  logic [NUM_SETS-1:0]           valid_q;

  logic [WORD_W-1:0] fill_word;
  logic [IDX_W-1:0]  sweep_idx;
  logic              hit_q;

  assign fill_word = count_i[WORD_W-1:0];
  assign sweep_idx = count_i[IDX_W-1:0];

  // Lookup, result one cycle after the address is sampled.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hit_q <= 1'b0;
    end else begin
      hit_q <= valid_q[addr_idx] && (tag_mem[addr_idx] == addr_tag);
    end
  end

  always_ff @(posedge clk_i) begin
    if_data_o <= data_mem[{addr_idx, addr_word}];            // Valid in the ack cycle.
  end

  // A line under refill is invalid until its last word lands.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_clr_i) begin
      valid_q[sweep_idx] <= 1'b0;
    end else if (cache_rw_i) begin
      valid_q[addr_idx] <= line_fill_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (line_fill_i) begin
      tag_mem[addr_idx] <= addr_tag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_rw_i) begin
      data_mem[{addr_idx, fill_word}] <= imem_data_i;
    end
  end

  assign cache_hit_o = hit_q;

  // Line base of the request plus the word being fetched.
  assign imem_addr_o = {if_addr_i[icache_pkg::ADDR_W-1:2+WORD_W], fill_word, 2'b00};

endmodule

`default_nettype wire

// ==== verilog/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // Bus widths.
  localparam int ADDR_W = 32;           // Byte address.
  localparam int DATA_W = 32;           // One instruction word.

  // Default cache geometry, both powers of two.
  localparam int DEF_NUM_SETS   = 16;   // Lines in the cache.
  localparam int DEF_LINE_WORDS = 4;    // Words per line.

  // Controller states.
  typedef enum logic [1:0] {
    ST_IDLE,                            // Lookup and hit response.
    ST_REFILL,                          // Line refill, one word per memory transaction.
    ST_DRAIN,                           // Waits out the memory transaction after a kill.
    ST_FLUSH                            // Sweeps the valid bits, one set per cycle.
  } icache_state_e;

  // Counter operations.
  typedef enum logic [1:0] {
    CNT_HOLD,                           // Keep the value.
    CNT_CLEAR,                          // Back to zero.
    CNT_INC                             // Step by one, wraps at the top.
  } cnt_op_e;

endpackage

`default_nettype wire

// ==== verilog/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int NUM_SETS   = icache_pkg::DEF_NUM_SETS,
  parameter int LINE_WORDS = icache_pkg::DEF_LINE_WORDS
) (
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,
  input  wire logic                          imem_sel_i,

  // Fetch to cache.
  input  wire logic                          if_req_i,
  input  wire logic                          if_req_kill_i,
  input  wire logic                          icache_flush_i,
  input  wire logic [icache_pkg::ADDR_W-1:0] if_addr_i,

  // Cache to fetch.
  output logic                               if_ack_o,
  output logic      [icache_pkg::DATA_W-1:0] if_data_o,

  // Memory to cache.
  input  wire logic                          imem_ack_i,
  input  wire logic [icache_pkg::DATA_W-1:0] imem_data_i,

  // Cache to memory.
  output logic                               imem_req_o,
  output logic      [icache_pkg::ADDR_W-1:0] imem_addr_o
);

  localparam int MAX_COUNT = (NUM_SETS > LINE_WORDS) ? NUM_SETS : LINE_WORDS;
  localparam int CNT_W     = $clog2(MAX_COUNT);

  logic                cache_hit;
  logic                cache_rw;
  logic                line_fill;
  logic                flush_clr;
  icache_pkg::cnt_op_e cnt_op;
  logic [CNT_W-1:0]    cnt_value;
  logic                cnt_last;
  logic                cnt_word_last;

  icache_controller u_controller (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .if_req_i        (if_req_i),
    .if_req_kill_i   (if_req_kill_i),
    .icache_flush_i  (icache_flush_i),
    .imem_sel_i      (imem_sel_i),
    .if_ack_o        (if_ack_o),
    .imem_ack_i      (imem_ack_i),
    .imem_req_o      (imem_req_o),
    .cache_hit_i     (cache_hit),
    .cnt_last_i      (cnt_last),
    .cnt_word_last_i (cnt_word_last),
    .cache_rw_o      (cache_rw),
    .line_fill_o     (line_fill),
    .flush_clr_o     (flush_clr),
    .cnt_op_o        (cnt_op)
  );

  icache_word_counter #(
    .MAX_COUNT  (MAX_COUNT),
    .WORD_COUNT (LINE_WORDS)
  ) u_counter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cnt_op_i    (cnt_op),
    .count_o     (cnt_value),
    .last_o      (cnt_last),
    .word_last_o (cnt_word_last)
  );

  icache_datapath #(
    .NUM_SETS   (NUM_SETS),
    .LINE_WORDS (LINE_WORDS)
  ) u_datapath (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cache_rw_i  (cache_rw),
    .line_fill_i (line_fill),
    .flush_clr_i (flush_clr),
    .cache_hit_o (cache_hit),
    .count_i     (cnt_value),
    .if_addr_i   (if_addr_i),
    .if_data_o   (if_data_o),
    .imem_data_i (imem_data_i),
    .imem_addr_o (imem_addr_o)
  );

endmodule

`default_nettype wire

// ==== verilog/icache_word_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

// Shared index counter, word index during refill and set index during flush.
module icache_word_counter #(
  parameter int MAX_COUNT  = 16,        // Counter range, a power of two.
  parameter int WORD_COUNT = 4          // Second end point, words per line.
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_n_i,
  input  wire icache_pkg::cnt_op_e          cnt_op_i,
  output logic [$clog2(MAX_COUNT)-1:0]      count_o,
  output logic                              last_o,
  output logic                              word_last_o
);

  localparam int CNT_W = $clog2(MAX_COUNT);

  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else begin
      unique case (cnt_op_i)
        icache_pkg::CNT_CLEAR: count_q <= '0;
        icache_pkg::CNT_INC:   count_q <= count_q + 1'b1;    // Wraps past MAX_COUNT-1.
        default:               count_q <= count_q;
      endcase
    end
  end

  assign count_o     = count_q;
  assign last_o      = (count_q == CNT_W'(MAX_COUNT - 1));   // End of the flush sweep.
  assign word_last_o = (count_q == CNT_W'(WORD_COUNT - 1));  // Last word of a refill.

endmodule

`default_nettype wire
